// ==== logic/dtlb_ctrl.sv ====
`timescale 1ns/1ps

module dtlb_ctrl #(
   parameter int set_bits = 6
) (
   input  logic                          clk,
   input  logic                          rst_n,
   // Lookup port
   input  logic                          re,
   input  logic [dtlb_pkg::vpn_bits-1:0] vaddr,
   // Hit from the tag compare, valid in the cycle after the RAM read
   input  logic                          hit,
   output logic                          ready,
   // RAM address and the page number being looked up
   output logic [set_bits-1:0]           rd_set,
   output logic [dtlb_pkg::vpn_bits-1:0] cur_vpn,
   // Strobes towards the lookup logic
   output logic                          fill,
   output logic                          hit_upd,
   // Walker side
   output dtlb_pkg::ptw_req_t            ptw_req,
   input  logic                          ptw_rsp_ready
);

   // idle       no lookup in flight, outputs hold the last result
   // comparing  RAM data for cur_vpn is out, tags are being compared
   // walking    waiting for the walker, then filling the victim way
   typedef enum logic [1:0] {
      st_idle,
      st_comparing,
      st_walking
   } state_t;

   state_t state_q;
   state_t state_d;

   // Request taken this cycle
   logic accept;

   // Walker ready, delayed by one cycle to line up with the response payload
   logic rsp_ready_q;

   // Single-cycle walk strobe
   logic walk_start;

   // Next state and strobes
   always_comb begin
      state_d    = state_q;
      ready      = 1'b0;
      hit_upd    = 1'b0;
      walk_start = 1'b0;
      fill       = 1'b0;

      case (state_q)
         st_idle: begin
            ready = 1'b1;
            if (re) begin
               state_d = st_comparing;
            end
         end

         st_comparing: begin
            if (hit) begin
               // Result is on the outputs now, so another request may go in
               ready   = 1'b1;
               hit_upd = 1'b1;
               if (re) begin
                  state_d = st_comparing;
               end else begin
                  state_d = st_idle;
               end
            end else begin
               // Miss, one walk per lookup
               walk_start = 1'b1;
               state_d    = st_walking;
            end
         end

         st_walking: begin
            // Registered response is in, write it into the victim way
            if (rsp_ready_q) begin
               fill    = 1'b1;
               state_d = st_idle;
            end
         end

         default: begin
            state_d = st_idle;
         end
      endcase
   end

   assign accept = re & ready;

   // New address goes straight to the RAM on acceptance
   // Otherwise keep reading the latched set so the outputs stay put
   assign rd_set = accept ? vaddr[set_bits-1:0] : cur_vpn[set_bits-1:0];

   // Walk address is the latched page number, constant while walking
   assign ptw_req.re  = walk_start;
   assign ptw_req.vpn = cur_vpn;

   // Control state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q     <= st_idle;
         rsp_ready_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         rsp_ready_q <= ptw_rsp_ready;
      end
   end

   // Request latch
   always_ff @(posedge clk) begin
      if (accept) begin
         cur_vpn <= vaddr;
      end
   end

endmodule

// ==== logic/dtlb_lookup.sv ====
`timescale 1ns/1ps

module dtlb_lookup #(
   parameter int set_bits = 6
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [dtlb_pkg::vpn_bits-1:0]  cur_vpn,
   // RAM read data of both ways
   input  dtlb_pkg::tlb_entry_t           way0_rdata,
   input  dtlb_pkg::tlb_entry_t           way1_rdata,
   input  logic                           hit_upd,
   input  logic                           fill,
   input  dtlb_pkg::ptw_rsp_t             ptw_rsp,
   output logic                           hit,
   // Fill path into the RAMs
   output logic                           we0,
   output logic                           we1,
   output dtlb_pkg::tlb_entry_t           wdata,
   // Result of the lookup
   output logic [dtlb_pkg::ppn_bits-1:0]  ppn,
   output logic [dtlb_pkg::flag_bits-1:0] flags
);

   localparam int sets = 1 << set_bits;

   // Per-set state, one valid bit per way and one victim bit
   logic [sets-1:0][1:0] valid_q;
   logic [sets-1:0]      repl_q;

   // Set and tag of the current lookup
   logic [set_bits-1:0]               cur_set;
   logic [dtlb_pkg::vpn_bits-1:0]     vpn_shift;
   logic [dtlb_pkg::tag_max_bits-1:0] cur_tag;

   logic [1:0] way_hit;
   logic       victim;

   // Walker response, captured on its ready strobe
   logic [dtlb_pkg::ppn_bits-1:0]  rsp_ppn_q;
   logic [dtlb_pkg::flag_bits-1:0] rsp_pd_flags_q;
   logic [dtlb_pkg::flag_bits-1:0] rsp_pt_flags_q;
   logic [dtlb_pkg::flag_bits-1:0] merged_flags;

   // Set from the low bits, tag from the rest, zero above the tag width
   assign cur_set   = cur_vpn[set_bits-1:0];
   assign vpn_shift = cur_vpn >> set_bits;
   assign cur_tag   = vpn_shift[dtlb_pkg::tag_max_bits-1:0];

   assign way_hit[0] = valid_q[cur_set][0] && (way0_rdata.tag == cur_tag);
   assign way_hit[1] = valid_q[cur_set][1] && (way1_rdata.tag == cur_tag);
   assign hit        = |way_hit;

   // Both ways never match at once, so way 1 only wins on its own hit
   assign ppn   = way_hit[1] ? way1_rdata.ppn : way0_rdata.ppn;
   assign flags = way_hit[1] ? way1_rdata.flags : way0_rdata.flags;

   always_ff @(posedge clk) begin
      if (ptw_rsp.ready) begin
         rsp_ppn_q      <= ptw_rsp.ppn;
         rsp_pd_flags_q <= ptw_rsp.pagedir_flags;
         rsp_pt_flags_q <= ptw_rsp.pagetab_flags;
      end
   end

   // Present and writeable need both levels, kernel and global need either
   always_comb begin
      merged_flags[dtlb_pkg::flag_present] =
         rsp_pd_flags_q[dtlb_pkg::flag_present] & rsp_pt_flags_q[dtlb_pkg::flag_present];
      merged_flags[dtlb_pkg::flag_writeable] =
         rsp_pd_flags_q[dtlb_pkg::flag_writeable] & rsp_pt_flags_q[dtlb_pkg::flag_writeable];
      merged_flags[dtlb_pkg::flag_kernel] =
         rsp_pd_flags_q[dtlb_pkg::flag_kernel] | rsp_pt_flags_q[dtlb_pkg::flag_kernel];
      merged_flags[dtlb_pkg::flag_global] =
         rsp_pd_flags_q[dtlb_pkg::flag_global] | rsp_pt_flags_q[dtlb_pkg::flag_global];
   end

   // Fill entry, written into the way the victim bit names
   always_comb begin
      wdata.tag   = cur_tag;
      wdata.flags = merged_flags;
      wdata.ppn   = rsp_ppn_q;
   end

   assign victim = repl_q[cur_set];
   assign we0    = fill & ~victim;
   assign we1    = fill & victim;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
         repl_q  <= '0;
      end else if (fill) begin
         valid_q[cur_set][victim] <= 1'b1;
         // Next fill goes to the other way
         repl_q[cur_set] <= ~victim;
      end else if (hit_upd) begin
         // Victim becomes the way that was not hit
         repl_q[cur_set] <= way_hit[0];
      end
   end

endmodule

// ==== logic/dtlb_pkg.sv ====
package dtlb_pkg;

   // Page number widths on both sides of the translation
   localparam int vpn_bits = 20;
   localparam int ppn_bits = 20;

   // Page flag field, same layout for directory, table and cached entry
   localparam int flag_bits = 4;

   // Bit positions inside a flag field
   localparam int flag_present   = 0;
   localparam int flag_writeable = 1;
   localparam int flag_kernel    = 2;
   localparam int flag_global    = 3;

   // Widest tag, reached at the smallest supported set count (set_bits of 4)
   localparam int tag_max_bits = vpn_bits - 4;

   // One cached translation
   // Tag bits above the tag width of the current set count are stored as zero
   typedef struct packed {
      logic [tag_max_bits-1:0] tag;
      logic [flag_bits-1:0]    flags;
      logic [ppn_bits-1:0]     ppn;
   } tlb_entry_t;

   // Request to the page table walker
   // re is a single-cycle strobe, vpn is held until the walker answers
   typedef struct packed {
      logic                re;
      logic [vpn_bits-1:0] vpn;
   } ptw_req_t;

   // Response from the page table walker
   // Every field is valid only in the cycle where ready is high
   typedef struct packed {
      logic                 ready;
      logic [ppn_bits-1:0]  ppn;
      logic [flag_bits-1:0] pagedir_flags;
      logic [flag_bits-1:0] pagetab_flags;
   } ptw_rsp_t;

endpackage

// ==== logic/dtlb_ram.sv ====
`timescale 1ns/1ps

module dtlb_ram #(
   parameter int set_bits = 6
) (
   input  logic                  clk,
   input  logic [set_bits-1:0]   set,
   input  logic                  we,
   input  dtlb_pkg::tlb_entry_t  wdata,
   output dtlb_pkg::tlb_entry_t  rdata
);

   // One entry per set
   localparam int depth = 1 << set_bits;

   // Translations of one way
   dtlb_pkg::tlb_entry_t mem [0:depth-1];

   // Single address for reads and writes, one cycle read latency
   // A write also shows the new entry on rdata in the following cycle,
   // so a filled entry can be presented without an extra read
   always_ff @(posedge clk) begin
      if (we) begin
         mem[set] <= wdata;
         rdata    <= wdata;
      end else begin
         rdata <= mem[set];
      end
   end

endmodule

// ==== logic/dtlb_top.sv ====
`timescale 1ns/1ps

module dtlb_top #(
   parameter int set_bits = 6
) (
   input  logic                           clk,
   input  logic                           rst_n,
   // Lookup port
   input  logic                           re,
   input  logic [dtlb_pkg::vpn_bits-1:0]  vaddr,
   output logic                           ready,
   output logic [dtlb_pkg::ppn_bits-1:0]  ppn,
   output logic [dtlb_pkg::flag_bits-1:0] flags,
   // Page table walker
   output dtlb_pkg::ptw_req_t             ptw_req,
   input  dtlb_pkg::ptw_rsp_t             ptw_rsp
);

   // Controller to lookup and RAMs
   logic [set_bits-1:0]           rd_set;
   logic [dtlb_pkg::vpn_bits-1:0] cur_vpn;
   logic                          fill;
   logic                          hit_upd;
   logic                          hit;

   // Fill path and read data of both ways
   logic                 we0;
   logic                 we1;
   dtlb_pkg::tlb_entry_t wdata;
   dtlb_pkg::tlb_entry_t way0_rdata;
   dtlb_pkg::tlb_entry_t way1_rdata;

   // Sequencing, request latch and walker strobe
   dtlb_ctrl #(
      .set_bits (set_bits)
   ) ctrl_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .re            (re),
      .vaddr         (vaddr),
      .hit           (hit),
      .ready         (ready),
      .rd_set        (rd_set),
      .cur_vpn       (cur_vpn),
      .fill          (fill),
      .hit_upd       (hit_upd),
      .ptw_req       (ptw_req),
      .ptw_rsp_ready (ptw_rsp.ready)
   );

   // Tag compare, replacement and fill entry
   dtlb_lookup #(
      .set_bits (set_bits)
   ) lookup_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cur_vpn    (cur_vpn),
      .way0_rdata (way0_rdata),
      .way1_rdata (way1_rdata),
      .hit_upd    (hit_upd),
      .fill       (fill),
      .ptw_rsp    (ptw_rsp),
      .hit        (hit),
      .we0        (we0),
      .we1        (we1),
      .wdata      (wdata),
      .ppn        (ppn),
      .flags      (flags)
   );

   // Both ways share address and write data, only the write strobes differ
   dtlb_ram #(.set_bits (set_bits)) way0_i (
      .clk (clk), .set (rd_set), .we (we0), .wdata (wdata), .rdata (way0_rdata)
   );

   dtlb_ram #(.set_bits (set_bits)) way1_i (
      .clk (clk), .set (rd_set), .we (we1), .wdata (wdata), .rdata (way1_rdata)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the DTLB testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module dtlb_tb -o dtlb_sim \
   && ./obj_dir/dtlb_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== verif/dtlb_checker.sv ====
`timescale 1ns/1ps

module dtlb_checker #(
   parameter int set_bits = 6
) (
   input  logic                           clk,
   input  logic                           rst_n,
   // Lookup port as the DUT sees it
   input  logic                           re,
   input  logic [dtlb_pkg::vpn_bits-1:0]  vaddr,
   input  logic                           exp_walk,
   input  logic                           ready,
   input  logic [dtlb_pkg::ppn_bits-1:0]  ppn,
   input  logic [dtlb_pkg::flag_bits-1:0] flags,
   input  dtlb_pkg::ptw_req_t             ptw_req,
   // Counts for the closing summary
   output int                             errors,
   output int                             accepted,
   output int                             results,
   output int                             walks,
   output logic                           idle
);

   localparam int sets = 1 << set_bits;

   // Reference TLB, full page number kept per way
   logic [dtlb_pkg::vpn_bits-1:0] model_vpn   [0:sets-1][0:1];
   logic                          model_valid [0:sets-1][0:1];
   logic                          model_repl  [0:sets-1];

   // Lookup in flight
   logic                          pend;
   logic [dtlb_pkg::vpn_bits-1:0] pend_vpn;
   logic                          pend_miss;
   logic                          walked;
   int                            cyc;

   // Last result, has to hold while ready stays high
   logic                           hold_valid;
   logic [dtlb_pkg::ppn_bits-1:0]  last_ppn;
   logic [dtlb_pkg::flag_bits-1:0] last_flags;
   logic                           reset_checked;

   // Page table rule of the walker
   function automatic logic [19:0] expect_ppn(input logic [19:0] vpn);
      return vpn ^ 20'h5a5a5;
   endfunction

   // Directory flags in vpn[3:0], table flags in vpn[7:4]
   function automatic logic [3:0] expect_flags(input logic [19:0] vpn);
      logic [3:0] pd;
      logic [3:0] pt;
      logic [3:0] f;
      pd = vpn[3:0];
      pt = vpn[7:4];
      f[dtlb_pkg::flag_present]   = pd[dtlb_pkg::flag_present] & pt[dtlb_pkg::flag_present];
      f[dtlb_pkg::flag_writeable] = pd[dtlb_pkg::flag_writeable] & pt[dtlb_pkg::flag_writeable];
      f[dtlb_pkg::flag_kernel]    = pd[dtlb_pkg::flag_kernel] | pt[dtlb_pkg::flag_kernel];
      f[dtlb_pkg::flag_global]    = pd[dtlb_pkg::flag_global] | pt[dtlb_pkg::flag_global];
      return f;
   endfunction

   task automatic report_mismatch(input string name, input logic [19:0] got,
                                  input logic [19:0] want);
      $display("ERR %0t %s: got %h expected %h", $time, name, got, want);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("%0t: %s", $time, msg);
      errors++;
   endtask

   // Look up and update the model, hit moves the victim, miss fills it
   task automatic model_access(input logic [19:0] vpn, output logic miss);
      int s;
      int w;
      int i;
      s    = int'(vpn[set_bits-1:0]);
      w    = 0;
      miss = 1'b1;
      for (i = 0; i < 2; i++) begin
         if (model_valid[s][i] && model_vpn[s][i] == vpn) begin
            miss = 1'b0;
            w    = i;
         end
      end
      if (!miss) begin
         model_repl[s] = (w == 0);
      end else begin
         w                = model_repl[s] ? 1 : 0;
         model_vpn[s][w]  = vpn;
         model_valid[s][w] = 1'b1;
         model_repl[s]    = ~model_repl[s];
      end
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < sets; s++) begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_repl[s]     = 1'b0;
         end
         errors        = 0;
         accepted      = 0;
         results       = 0;
         walks         = 0;
         pend          = 1'b0;
         walked        = 1'b0;
         hold_valid    = 1'b0;
         reset_checked = 1'b0;
         cyc           = 0;
         idle          = 1'b1;
      end else begin
         // First cycle out of reset
         if (!reset_checked) begin
            reset_checked = 1'b1;
            if (ready !== 1'b1) report_failure("ready is not high after reset");
            if (ptw_req.re !== 1'b0) report_failure("walk request is active after reset");
         end
         if (pend) cyc++;

         // Walker strobe, one per miss and one cycle after acceptance
         if (ptw_req.re === 1'b1) begin
            walks++;
            if (!pend) begin
               report_failure("walk request with no lookup outstanding");
            end else if (!pend_miss) begin
               report_failure($sformatf("walk request for cached vpn %h", pend_vpn));
            end else if (walked) begin
               report_failure($sformatf("second walk request for vpn %h", pend_vpn));
            end else if (cyc != 1) begin
               report_failure($sformatf("walk request %0d cycles after acceptance", cyc));
            end
            if (pend && ptw_req.vpn !== pend_vpn) begin
               report_mismatch("ptw_req.vpn", ptw_req.vpn, pend_vpn);
            end
            walked = pend;
         end else if (pend && walked && ptw_req.vpn !== pend_vpn) begin
            // Walk address has to stay put until the response
            report_mismatch("ptw_req.vpn", ptw_req.vpn, pend_vpn);
         end

         // Result on the first ready after acceptance
         if (pend && ready === 1'b1) begin
            results++;
            if (!pend_miss && cyc != 1) begin
               report_failure($sformatf("hit on vpn %h came %0d cycles late", pend_vpn, cyc));
            end
            if (pend_miss && !walked) begin
               report_failure($sformatf("vpn %h returned without a walk", pend_vpn));
            end
            if (ppn !== expect_ppn(pend_vpn)) report_mismatch("ppn", ppn, expect_ppn(pend_vpn));
            if (flags !== expect_flags(pend_vpn)) begin
               report_mismatch("flags", 20'(flags), 20'(expect_flags(pend_vpn)));
            end
            last_ppn   = expect_ppn(pend_vpn);
            last_flags = expect_flags(pend_vpn);
            hold_valid = 1'b1;
            pend       = 1'b0;
         end else if (pend && !pend_miss && cyc == 1) begin
            report_failure($sformatf("hit on vpn %h missed the next cycle", pend_vpn));
         end else if (!pend && ready !== 1'b1) begin
            report_failure("ready is low with no lookup outstanding");
         end else if (!pend && hold_valid) begin
            if (ppn !== last_ppn) report_mismatch("ppn", ppn, last_ppn);
            if (flags !== last_flags) report_mismatch("flags", 20'(flags), 20'(last_flags));
         end

         // Acceptance, model decides hit or walk
         if (re === 1'b1 && ready === 1'b1) begin
            accepted++;
            pend_vpn = vaddr;
            model_access(vaddr, pend_miss);
            if (pend_miss !== exp_walk) begin
               report_failure($sformatf("pattern says walk=%0d for vpn %h, model says %0d",
                                        exp_walk, vaddr, pend_miss));
            end
            pend       = 1'b1;
            walked     = 1'b0;
            cyc        = 0;
            hold_valid = 1'b0;
         end
         idle = !pend;
      end
   end

endmodule

// ==== verif/dtlb_patterns.txt ====
// vpn (hex)  idle gap before the request  walker latency  walk expected (1) or hit (0)
// Gap and latency in clock cycles, a gap of 0 raises the request right after the last one
00123 0 3 1
00123 0 2 0
00123 0 2 0
0a7e1 2 4 1
0a7e1 0 2 0
00123 0 2 0
12345 1 2 1
6a785 0 5 1
12345 0 2 0
0abc5 0 3 1
12345 0 2 0
6a785 0 2 1
3f0ff 0 40 1
0a7e1 0 2 0
3f0ff 0 2 0
6a785 3 2 0
0abc5 0 6 1
12345 0 3 1
0abc5 0 1 0
ffffe 1 1 1

// ==== verif/dtlb_tb.sv ====
`timescale 1ns/1ps

module dtlb_tb;

   localparam int set_bits     = 6;
   localparam int max_lines    = 64;
   localparam int reset_cycles = 5;

   logic                           clk;
   logic                           rst_n;
   logic                           re;
   logic [dtlb_pkg::vpn_bits-1:0]  vaddr;
   logic                           exp_walk;
   logic                           ready;
   logic [dtlb_pkg::ppn_bits-1:0]  ppn;
   logic [dtlb_pkg::flag_bits-1:0] flags;
   dtlb_pkg::ptw_req_t             ptw_req;
   dtlb_pkg::ptw_rsp_t             ptw_rsp;

   // Lookups from the pattern file
   logic [19:0] pat_vpn  [0:max_lines-1];
   int          pat_gap  [0:max_lines-1];
   int          pat_lat  [0:max_lines-1];
   logic        pat_walk [0:max_lines-1];
   int          n_lines;
   int          exp_walks;

   int limit_cycles;
   int tb_errors;

   // Walker latency of the lookup last accepted
   int acc_lat;

   int   chk_errors;
   int   chk_accepted;
   int   chk_results;
   int   chk_walks;
   logic chk_idle;

   dtlb_top #(.set_bits (set_bits)) dtlb_top_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .re      (re),
      .vaddr   (vaddr),
      .ready   (ready),
      .ppn     (ppn),
      .flags   (flags),
      .ptw_req (ptw_req),
      .ptw_rsp (ptw_rsp)
   );

   dtlb_checker #(.set_bits (set_bits)) chk (
      .clk      (clk),
      .rst_n    (rst_n),
      .re       (re),
      .vaddr    (vaddr),
      .exp_walk (exp_walk),
      .ready    (ready),
      .ppn      (ppn),
      .flags    (flags),
      .ptw_req  (ptw_req),
      .errors   (chk_errors),
      .accepted (chk_accepted),
      .results  (chk_results),
      .walks    (chk_walks),
      .idle     (chk_idle)
   );

   task automatic read_patterns();
      int          fd;
      int          n;
      int          g;
      int          l;
      int          w;
      logic [19:0] v;
      string       line;
      n_lines   = 0;
      exp_walks = 0;
      fd = $fopen("verif/dtlb_patterns.txt", "r");
      if (fd == 0) begin
         $display("Could not open verif/dtlb_patterns.txt for reading");
         tb_errors++;
      end else begin
         while (!$feof(fd) && n_lines < max_lines) begin
            line = "";
            n = $fgets(line, fd);
            // Blank and comment lines carry no lookup
            if (n > 1 && line.substr(0, 1) != "//") begin
               n = $sscanf(line, "%h %d %d %d", v, g, l, w);
               if (n == 4) begin
                  pat_vpn[n_lines]  = v;
                  pat_gap[n_lines]  = g;
                  pat_lat[n_lines]  = l;
                  pat_walk[n_lines] = (w != 0);
                  if (w != 0) exp_walks++;
                  n_lines++;
               end else begin
                  $display("Pattern line could not be parsed: %s", line);
                  tb_errors++;
               end
            end
         end
         $fclose(fd);
         if (n_lines == 0) begin
            $display("The pattern file holds no lookups");
            tb_errors++;
         end
      end
   endtask

   // Idle gap, then hold the request until ready lets it in
   task automatic run_lookup(input int i);
      if (pat_gap[i] > 0) begin
         re = 1'b0;
         repeat (pat_gap[i]) @(negedge clk);
      end
      re       = 1'b1;
      vaddr    = pat_vpn[i];
      exp_walk = pat_walk[i];
      while (ready !== 1'b1) @(negedge clk);
      acc_lat = pat_lat[i];
      @(negedge clk);
   endtask

   task automatic wait_idle();
      while (chk_idle !== 1'b1) @(negedge clk);
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin : stimulus
      int budget;
      re        = 1'b0;
      vaddr     = '0;
      exp_walk  = 1'b0;
      rst_n     = 1'b0;
      acc_lat   = 1;
      tb_errors = 0;
      budget    = 0;
      read_patterns();
      for (int i = 0; i < n_lines; i++) begin
         budget += pat_gap[i] + pat_lat[i] + 4;
      end
      limit_cycles = 2 * budget + reset_cycles + 10;

      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      for (int i = 0; i < n_lines; i++) begin
         run_lookup(i);
      end
      re = 1'b0;
      wait_idle();
      repeat (3) @(negedge clk);

      // Walk count against the pattern file
      if (chk_walks != exp_walks) begin
         $display("ERR %0t ptw_req.re pulses: got %0d expected %0d", $time, chk_walks, exp_walks);
         tb_errors++;
      end
      $display("Lookups %0d, results %0d, walks %0d, checker errors %0d, testbench errors %0d",
               chk_accepted, chk_results, chk_walks, chk_errors, tb_errors);
      if (chk_errors == 0 && tb_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Walker model answering after the latency of the accepted line
   initial begin : walker
      logic [19:0] walk_vpn;
      int          lat;
      ptw_rsp = '0;
      forever begin
         @(negedge clk);
         if (rst_n && ptw_req.re) begin
            walk_vpn = ptw_req.vpn;
            lat      = acc_lat;
            repeat (lat) @(negedge clk);
            ptw_rsp.ready         = 1'b1;
            ptw_rsp.ppn           = walk_vpn ^ 20'h5a5a5;
            ptw_rsp.pagedir_flags = walk_vpn[3:0];
            ptw_rsp.pagetab_flags = walk_vpn[7:4];
            @(negedge clk);
            ptw_rsp = '0;
         end
      end
   end

   initial begin : watchdog
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
      $display("** FAIL **");
      $finish;
   end

endmodule

// ==== vlog.f ====
logic/dtlb_pkg.sv
logic/dtlb_ram.sv
logic/dtlb_ctrl.sv
logic/dtlb_lookup.sv
logic/dtlb_top.sv
verif/dtlb_checker.sv
verif/dtlb_tb.sv
